// ==== rvPkg.sv ====
`default_nettype none

package rvPkg;

    localparam int xlen = 32;

    // major opcodes of the supported subset
    typedef enum logic [6:0] {
        opLoad   = 7'd3,
        opItype  = 7'd19,
        opStore  = 7'd35,
        opRtype  = 7'd51,
        opBranch = 7'd99,
        opJal    = 7'd111
    } opcodeT;

    // class handed from the main decoder to the ALU decoder
    typedef enum logic [1:0] {
        aluOpAdd   = 2'b00,
        aluOpSub   = 2'b01,
        aluOpFunct = 2'b10
    } aluOpT;

    typedef enum logic [2:0] {
        aluAdd = 3'd0,
        aluSub = 3'd1,
        aluAnd = 3'd2,
        aluOr  = 3'd3,
        aluSlt = 3'd4,
        aluXor = 3'd5
    } aluCtrlT;

    typedef enum logic [1:0] {
        immI = 2'b00,
        immS = 2'b01,
        immB = 2'b10,
        immJ = 2'b11
    } immSrcT;

    // write-back source
    typedef enum logic [1:0] {
        resAlu = 2'b00,
        resMem = 2'b01,
        resPc4 = 2'b10
    } resSrcT;

endpackage

`default_nettype wire

// ==== ctrlIf.sv ====
`timescale 1ns/1ps
`default_nettype none

interface ctrlIf;

    logic           regWrite;
    logic           aluSrc;
    rvPkg::immSrcT  immSrc;
    rvPkg::resSrcT  resSrc;
    logic           pcSrc;
    rvPkg::aluCtrlT aluCtrl;
    // back from the ALU
    logic           zero;

    modport controller (
        output regWrite,
        output aluSrc,
        output immSrc,
        output resSrc,
        output pcSrc,
        output aluCtrl,
        input  zero
    );

    modport datapath (
        input  regWrite,
        input  aluSrc,
        input  immSrc,
        input  resSrc,
        input  pcSrc,
        input  aluCtrl,
        output zero
    );

endinterface

`default_nettype wire

// ==== mainDeco.sv ====
`timescale 1ns/1ps
`default_nettype none

module mainDeco (
    input  wire [6:0]    op,
    output logic         branch,
    output logic         memWrite,
    output logic         aluSrc,
    output logic         regWrite,
    output rvPkg::resSrcT resSrc,
    output rvPkg::immSrcT immSrc,
    output logic         jump,
    output rvPkg::aluOpT  aluOp
);

    always_comb
    begin
        // anything not listed below runs as a nop
        branch   = 1'b0;
        memWrite = 1'b0;
        aluSrc   = 1'b0;
        regWrite = 1'b0;
        resSrc   = rvPkg::resAlu;
        immSrc   = rvPkg::immI;
        jump     = 1'b0;
        aluOp    = rvPkg::aluOpAdd;

        case (op)
            rvPkg::opLoad:
            begin
                aluSrc   = 1'b1;
                regWrite = 1'b1;
                resSrc   = rvPkg::resMem;
            end
            rvPkg::opStore:
            begin
                memWrite = 1'b1;
                aluSrc   = 1'b1;
                immSrc   = rvPkg::immS;
            end
            rvPkg::opRtype:
            begin
                regWrite = 1'b1;
                aluOp    = rvPkg::aluOpFunct;
            end
            rvPkg::opItype:
            begin
                aluSrc   = 1'b1;
                regWrite = 1'b1;
                aluOp    = rvPkg::aluOpFunct;
            end
            rvPkg::opBranch:
            begin
                branch = 1'b1;
                immSrc = rvPkg::immB;
                aluOp  = rvPkg::aluOpSub;
            end
            rvPkg::opJal:
            begin
                jump     = 1'b1;
                regWrite = 1'b1;
                immSrc   = rvPkg::immJ;
                resSrc   = rvPkg::resPc4;
            end
            default:
            begin
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== controller.sv ====
`timescale 1ns/1ps
`default_nettype none

module controller (
    input  wire [6:0] op,
    input  wire [2:0] funct3,
    input  wire       funct7b5,
    output logic      memWrite,
    ctrlIf.controller ctrl
);

    logic          branch;
    logic          jump;
    logic          rTypeSub;
    rvPkg::aluOpT  aluOp;

    mainDeco uMainDeco (
        .op       (op),
        .branch   (branch),
        .memWrite (memWrite),
        .aluSrc   (ctrl.aluSrc),
        .regWrite (ctrl.regWrite),
        .resSrc   (ctrl.resSrc),
        .immSrc   (ctrl.immSrc),
        .jump     (jump),
        .aluOp    (aluOp)
    );

    // funct7 bit 5 selects sub only for register-register ops
    assign rTypeSub = funct7b5 & op[5];

    always_comb
    begin
        ctrl.aluCtrl = rvPkg::aluAdd;
        case (aluOp)
            rvPkg::aluOpSub:
                ctrl.aluCtrl = rvPkg::aluSub;
            rvPkg::aluOpFunct:
            begin
                case (funct3)
                    3'b000: ctrl.aluCtrl = rTypeSub ? rvPkg::aluSub : rvPkg::aluAdd;
                    3'b010: ctrl.aluCtrl = rvPkg::aluSlt;
                    3'b100: ctrl.aluCtrl = rvPkg::aluXor;
                    3'b110: ctrl.aluCtrl = rvPkg::aluOr;
                    3'b111: ctrl.aluCtrl = rvPkg::aluAnd;
                    default: ctrl.aluCtrl = rvPkg::aluAdd;
                endcase
            end
            default:
                ctrl.aluCtrl = rvPkg::aluAdd;
        endcase
    end

    // beq is taken when the subtraction is zero
    assign ctrl.pcSrc = (branch & ctrl.zero) | jump;

endmodule

`default_nettype wire

// ==== alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  wire [rvPkg::xlen-1:0] a,
    input  wire [rvPkg::xlen-1:0] b,
    input  wire rvPkg::aluCtrlT   aluCtrl,
    output logic [rvPkg::xlen-1:0] result,
    output logic                   zero
);

    logic lessThan;

    // signed compare for slt
    assign lessThan = $signed(a) < $signed(b);

    always_comb
    begin
        case (aluCtrl)
            rvPkg::aluAdd: result = a + b;
            rvPkg::aluSub: result = a - b;
            rvPkg::aluAnd: result = a & b;
            rvPkg::aluOr:  result = a | b;
            rvPkg::aluSlt: result = {{(rvPkg::xlen-1){1'b0}}, lessThan};
            rvPkg::aluXor: result = a ^ b;
            default:       result = a + b;
        endcase
    end

    assign zero = (result == '0);

endmodule

`default_nettype wire

// ==== regFile.sv ====
`timescale 1ns/1ps
`default_nettype none

module regFile (
    input  wire                    clk,
    input  wire                    arstN,
    input  wire                    we,
    input  wire [4:0]              ra1,
    input  wire [4:0]              ra2,
    input  wire [4:0]              wa,
    input  wire [rvPkg::xlen-1:0]  wd,
    output logic [rvPkg::xlen-1:0] rd1,
    output logic [rvPkg::xlen-1:0] rd2
);

    // x0 has no storage
    logic [rvPkg::xlen-1:0] regs [1:31];

    always_ff @(posedge clk or negedge arstN)
    begin
        if (!arstN)
        begin
            for (int i = 1; i < 32; i++)
                regs[i] <= '0;
        end
        else if (we && (wa != 5'd0))
            regs[wa] <= wd;
    end

    assign rd1 = (ra1 == 5'd0) ? '0 : regs[ra1];
    assign rd2 = (ra2 == 5'd0) ? '0 : regs[ra2];

endmodule

`default_nettype wire

// ==== datapath.sv ====
`timescale 1ns/1ps
`default_nettype none

module datapath (
    input  wire                    clk,
    input  wire                    arstN,
    input  wire                    run,
    input  wire [rvPkg::xlen-1:0]  instr,
    input  wire [rvPkg::xlen-1:0]  readData,
    ctrlIf.datapath                ctrl,
    output logic [6:0]             op,
    output logic [2:0]             funct3,
    output logic                   funct7b5,
    output logic [rvPkg::xlen-1:0] pc,
    output logic [rvPkg::xlen-1:0] aluResult,
    output logic [rvPkg::xlen-1:0] writeData
);

    logic [rvPkg::xlen-1:0] pcPlus4;
    logic [rvPkg::xlen-1:0] pcTarget;
    logic [rvPkg::xlen-1:0] immExt;
    logic [rvPkg::xlen-1:0] srcA;
    logic [rvPkg::xlen-1:0] srcB;
    logic [rvPkg::xlen-1:0] result;
    logic                   regWe;

    assign op       = instr[6:0];
    assign funct3   = instr[14:12];
    assign funct7b5 = instr[30];

    // ==========================================================
    // next pc
    // ==========================================================
    assign pcPlus4  = pc + 4;
    assign pcTarget = pc + immExt;

    always_ff @(posedge clk or negedge arstN)
    begin
        if (!arstN)
            pc <= '0;
        else if (run)
            pc <= ctrl.pcSrc ? pcTarget : pcPlus4;
    end

    // ==========================================================
    // immediate extension
    // ==========================================================
    always_comb
    begin
        case (ctrl.immSrc)
            rvPkg::immI: immExt = {{(rvPkg::xlen-12){instr[31]}}, instr[31:20]};
            rvPkg::immS: immExt = {{(rvPkg::xlen-12){instr[31]}}, instr[31:25], instr[11:7]};
            rvPkg::immB: immExt = {{(rvPkg::xlen-12){instr[31]}}, instr[7], instr[30:25],
                                   instr[11:8], 1'b0};
            rvPkg::immJ: immExt = {{(rvPkg::xlen-20){instr[31]}}, instr[19:12], instr[20],
                                   instr[30:21], 1'b0};
        endcase
    end

    // ==========================================================
    // register file, ALU and write-back
    // ==========================================================
    assign regWe = ctrl.regWrite & run;

    regFile uRegFile (
        .clk   (clk),
        .arstN (arstN),
        .we    (regWe),
        .ra1   (instr[19:15]),
        .ra2   (instr[24:20]),
        .wa    (instr[11:7]),
        .wd    (result),
        .rd1   (srcA),
        .rd2   (writeData)
    );

    assign srcB = ctrl.aluSrc ? immExt : writeData;

    alu uAlu (
        .a       (srcA),
        .b       (srcB),
        .aluCtrl (ctrl.aluCtrl),
        .result  (aluResult),
        .zero    (ctrl.zero)
    );

    always_comb
    begin
        case (ctrl.resSrc)
            rvPkg::resMem: result = readData;
            rvPkg::resPc4: result = pcPlus4;
            default:       result = aluResult;
        endcase
    end

endmodule

`default_nettype wire

// ==== instrMem.sv ====
`timescale 1ns/1ps
`default_nettype none

module instrMem #(
    parameter int imemDepth = 64
) (
    input  wire                    clk,
    input  wire                    we,
    input  wire [rvPkg::xlen-1:0]  wAddr,
    input  wire [rvPkg::xlen-1:0]  wData,
    input  wire [rvPkg::xlen-1:0]  addr,
    output logic [rvPkg::xlen-1:0] rData
);

    localparam int idxBits = $clog2(imemDepth);

    logic [rvPkg::xlen-1:0] mem [imemDepth];

    // load port takes a word index
    always_ff @(posedge clk)
    begin
        if (we)
            mem[wAddr[idxBits-1:0]] <= wData;
    end

    // fetch uses the byte pc
    assign rData = mem[addr[idxBits+1:2]];

endmodule

`default_nettype wire

// ==== dataMem.sv ====
`timescale 1ns/1ps
`default_nettype none

module dataMem #(
    parameter int dmemDepth = 64
) (
    input  wire                    clk,
    input  wire                    we,
    input  wire [rvPkg::xlen-1:0]  addr,
    input  wire [rvPkg::xlen-1:0]  wData,
    output logic [rvPkg::xlen-1:0] rData
);

    localparam int idxBits = $clog2(dmemDepth);

    logic [rvPkg::xlen-1:0] mem [dmemDepth];
    logic [idxBits-1:0]     idx;

    // byte offset bits dropped and upper bits wrap
    assign idx = addr[idxBits+1:2];

    always_ff @(posedge clk)
    begin
        if (we)
            mem[idx] <= wData;
    end

    assign rData = mem[idx];

endmodule

`default_nettype wire

// ==== riscvTop.sv ====
`timescale 1ns/1ps
`default_nettype none

module riscvTop #(
    parameter int imemDepth = 64,
    parameter int dmemDepth = 64
) (
    input  wire                    clk,
    input  wire                    arstN,
    input  wire                    run,
    input  wire                    progWe,
    input  wire [rvPkg::xlen-1:0]  progAddr,
    input  wire [rvPkg::xlen-1:0]  progData,
    output logic [rvPkg::xlen-1:0] pc,
    output logic                   memWe,
    output logic [rvPkg::xlen-1:0] memAddr,
    output logic [rvPkg::xlen-1:0] memWData
);

    logic [6:0]             op;
    logic [2:0]             funct3;
    logic                   funct7b5;
    logic                   memWrite;
    logic [rvPkg::xlen-1:0] instr;
    logic [rvPkg::xlen-1:0] readData;

    ctrlIf ctrlBus ();

    // ==========================================================
    // core
    // ==========================================================
    controller uController (
        .op       (op),
        .funct3   (funct3),
        .funct7b5 (funct7b5),
        .memWrite (memWrite),
        .ctrl     (ctrlBus.controller)
    );

    datapath uDatapath (
        .clk       (clk),
        .arstN     (arstN),
        .run       (run),
        .instr     (instr),
        .readData  (readData),
        .ctrl      (ctrlBus.datapath),
        .op        (op),
        .funct3    (funct3),
        .funct7b5  (funct7b5),
        .pc        (pc),
        .aluResult (memAddr),
        .writeData (memWData)
    );

    // stores only while running
    assign memWe = memWrite & run;

    // ==========================================================
    // memories
    // ==========================================================
    instrMem #(
        .imemDepth (imemDepth)
    ) uInstrMem (
        .clk   (clk),
        .we    (progWe),
        .wAddr (progAddr),
        .wData (progData),
        .addr  (pc),
        .rData (instr)
    );

    dataMem #(
        .dmemDepth (dmemDepth)
    ) uDataMem (
        .clk   (clk),
        .we    (memWe),
        .addr  (memAddr),
        .wData (memWData),
        .rData (readData)
    );

endmodule

`default_nettype wire

// ==== riscvSva.sv ====
`timescale 1ns/1ps
`default_nettype none

module riscvSva (
    input wire clk,
    input wire arstN,
    input wire run,
    input wire memWe,
    input wire memWrite,
    input wire regWrite,
    input wire pcSrc,
    input wire branch,
    input wire jump
);

    // a store never writes a register
    assert property (@(posedge clk) disable iff (!arstN) run |-> !(memWrite && regWrite))
        else $error("memWrite and regWrite high together");

    assert property (@(posedge clk) disable iff (!arstN) !run |-> !memWe)
        else $error("memWe high while run is low");

    assert property (@(posedge clk) disable iff (!arstN) (run && pcSrc) |-> (branch || jump))
        else $error("pcSrc high without branch or jump");

endmodule

bind riscvTop riscvSva uSva (
    .clk      (clk),
    .arstN    (arstN),
    .run      (run),
    .memWe    (memWe),
    .memWrite (memWrite),
    .regWrite (ctrlBus.regWrite),
    .pcSrc    (ctrlBus.pcSrc),
    .branch   (uController.branch),
    .jump     (uController.jump)
);

`default_nettype wire

// ==== riscvTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module riscvTb;

    localparam int imemDepth = 64;
    localparam int dmemDepth = 64;
    localparam int numTests  = 8;
    // forward-only programs execute at most one pass over the instruction memory
    localparam int maxCycles = imemDepth * numTests + 50;

    logic        clk;
    logic        arstN;
    logic        run;
    logic        progWe;
    logic [31:0] progAddr;
    logic [31:0] progData;
    logic [31:0] pc;
    logic        memWe;
    logic [31:0] memAddr;
    logic [31:0] memWData;

    integer      seed;
    int          errorCount = 0;
    int          checkCount = 0;
    int          runCycles = 0;
    int          progLen;
    logic [31:0] prog [imemDepth];

    // instruction-set model state
    logic [31:0] mRegs [32];
    logic [31:0] mMem [dmemDepth];
    logic [31:0] mPc;

    riscvTop #(
        .imemDepth (imemDepth),
        .dmemDepth (dmemDepth)
    ) UUT (
        .clk      (clk),
        .arstN    (arstN),
        .run      (run),
        .progWe   (progWe),
        .progAddr (progAddr),
        .progData (progData),
        .pc       (pc),
        .memWe    (memWe),
        .memAddr  (memAddr),
        .memWData (memWData)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    always @(posedge clk)
    begin
        if (run)
            runCycles = runCycles + 1;
        if (runCycles > maxCycles)
        begin
            $display("timeout: program did not reach its end loop within %0d cycles", maxCycles);
            $display("Simulation failed");
            $finish;
        end
    end

    // ============================================================
    // instruction encoding and program generation
    // ============================================================
    function automatic int unsigned randBelow(input int unsigned n);
        return $unsigned($random(seed)) % n;
    endfunction

    function automatic logic [4:0] randReg();
        return 5'(randBelow(8));
    endfunction

    function automatic logic [31:0] encR(input logic [2:0] f3, input logic sub,
                                         input logic [4:0] rd, input logic [4:0] rs1,
                                         input logic [4:0] rs2);
        return {1'b0, sub, 5'd0, rs2, rs1, f3, rd, rvPkg::opRtype};
    endfunction

    function automatic logic [31:0] encI(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] encS(input logic [11:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], rvPkg::opStore};
    endfunction

    function automatic logic [31:0] encB(input logic [12:0] imm, input logic [4:0] rs1,
                                         input logic [4:0] rs2);
        return {imm[12], imm[10:5], rs2, rs1, 3'b000, imm[4:1], imm[11], rvPkg::opBranch};
    endfunction

    function automatic logic [31:0] encJ(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, rvPkg::opJal};
    endfunction

    function automatic logic [31:0] randAlu();
        int         pick;
        logic [2:0] f3;
        pick = randBelow(6);
        case (pick)
            0, 1: f3 = 3'b000;
            2: f3 = 3'b111;
            3: f3 = 3'b110;
            4: f3 = 3'b010;
            default: f3 = 3'b100;
        endcase
        if (randBelow(2) == 0)
            return encR(f3, pick == 1, randReg(), randReg(), randReg());
        return encI(12'($random(seed)), randReg(), f3, randReg(), rvPkg::opItype);
    endfunction

    // opcode outside the supported subset, zero fairly often
    function automatic logic [6:0] unknownOp();
        logic [6:0] op;
        if (randBelow(3) == 0)
            return 7'd0;
        do
            op = 7'($random(seed));
        while (op inside {rvPkg::opLoad, rvPkg::opItype, rvPkg::opStore,
                          rvPkg::opRtype, rvPkg::opBranch, rvPkg::opJal});
        return op;
    endfunction

    task automatic buildProgram();
        int          pos;
        int          skip;
        logic [4:0]  ra;
        logic [4:0]  rb;
        logic [4:0]  rl;
        logic [11:0] off;
        logic [31:0] word;
        pos = 0;
        while (pos < imemDepth - 6)
        begin
            ra = randReg();
            rb = randReg();
            off = 12'($random(seed));
            skip = 1 + randBelow(3);
            case (randBelow(5))
                0:
                begin
                    prog[pos] = randAlu();
                    prog[pos+1] = encS(off, prog[pos][11:7], ra);
                    pos = pos + 2;
                end
                1:
                begin
                    do
                        rl = 5'(1 + randBelow(7));
                    while (rl == ra);
                    prog[pos] = encS(off, rb, ra);
                    prog[pos+1] = encI(off, ra, 3'b010, rl, rvPkg::opLoad);
                    prog[pos+2] = encS(off, rl, ra);
                    pos = pos + 3;
                end
                2:
                begin
                    // equal operands half of the time
                    prog[pos] = encB(13'((skip + 1) * 4), ra, (randBelow(2) == 0) ? ra : rb);
                    for (int i = 1; i <= skip; i++)
                        prog[pos+i] = randAlu();
                    pos = pos + skip + 1;
                end
                3:
                begin
                    rl = 5'(1 + randBelow(7));
                    prog[pos] = encJ(21'((skip + 1) * 4), rl);
                    for (int i = 1; i <= skip; i++)
                        prog[pos+i] = randAlu();
                    prog[pos+skip+1] = encS(off, rl, 5'd0);
                    pos = pos + skip + 2;
                end
                default:
                begin
                    word = $random(seed);
                    word[6:0] = unknownOp();
                    prog[pos] = word;
                    prog[pos+1] = encS(off, word[11:7], ra);
                    pos = pos + 2;
                end
            endcase
        end
        // self-loop marks the end
        prog[pos] = encJ(21'd0, 5'd0);
        progLen = pos + 1;
    endtask

    // ============================================================
    // instruction-set model
    // ============================================================
    function automatic logic [31:0] aluModel(input logic [2:0] f3, input logic sub,
                                             input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'b000: return sub ? a - b : a + b;
            3'b010: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b100: return a ^ b;
            3'b110: return a | b;
            3'b111: return a & b;
            default: return a + b;
        endcase
    endfunction

    function automatic int wordIdx(input logic [31:0] addr);
        return (addr >> 2) % dmemDepth;
    endfunction

    task automatic writeReg(input logic [4:0] rd, input logic [31:0] value);
        if (rd != 5'd0)
            mRegs[rd] = value;
    endtask

    task automatic stepModel();
        logic [31:0] ins;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] immI;
        logic [31:0] immS;
        logic [31:0] immB;
        logic [31:0] immJ;
        logic [31:0] nextPc;
        ins = prog[(mPc >> 2) % imemDepth];
        a = mRegs[ins[19:15]];
        b = mRegs[ins[24:20]];
        immI = {{20{ins[31]}}, ins[31:20]};
        immS = {{20{ins[31]}}, ins[31:25], ins[11:7]};
        immB = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
        immJ = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
        nextPc = mPc + 4;
        case (ins[6:0])
            rvPkg::opRtype: writeReg(ins[11:7], aluModel(ins[14:12], ins[30], a, b));
            rvPkg::opItype: writeReg(ins[11:7], aluModel(ins[14:12], 1'b0, a, immI));
            rvPkg::opLoad: writeReg(ins[11:7], mMem[wordIdx(a + immI)]);
            rvPkg::opStore: mMem[wordIdx(a + immS)] = b;
            rvPkg::opBranch:
            begin
                if (a == b)
                    nextPc = mPc + immB;
            end
            rvPkg::opJal:
            begin
                writeReg(ins[11:7], mPc + 4);
                nextPc = mPc + immJ;
            end
            default:
            begin
            end
        endcase
        mPc = nextPc;
    endtask

    // ============================================================
    // checks and test sequence
    // ============================================================
    task automatic reportMismatch(input string name, input logic [31:0] got,
                                  input logic [31:0] exp);
        errorCount = errorCount + 1;
        $display("** Error at %0t ns: %s = 0x%h, expected 0x%h", $time, name, got, exp);
    endtask

    task automatic checkOutputs();
        logic [31:0] ins;
        logic [31:0] expAddr;
        logic        expWe;
        ins = prog[(mPc >> 2) % imemDepth];
        expWe = run && (ins[6:0] == rvPkg::opStore);
        expAddr = mRegs[ins[19:15]] + {{20{ins[31]}}, ins[31:25], ins[11:7]};
        checkCount = checkCount + 1;
        if (pc !== mPc)
            reportMismatch("pc", pc, mPc);
        if (memWe !== expWe)
            reportMismatch("memWe", {31'd0, memWe}, {31'd0, expWe});
        if (expWe && memAddr !== expAddr)
            reportMismatch("memAddr", memAddr, expAddr);
        if (expWe && memWData !== mRegs[ins[24:20]])
            reportMismatch("memWData", memWData, mRegs[ins[24:20]]);
    endtask

    task automatic runTest(input int t);
        int errBefore;
        int atEnd;
        errBefore = errorCount;
        buildProgram();
        @(posedge clk);
        arstN <= 1'b0;
        run <= 1'b0;
        repeat (2) @(posedge clk);
        arstN <= 1'b1;
        for (int i = 0; i < 32; i++)
            mRegs[i] = '0;
        mPc = '0;
        for (int i = 0; i < progLen; i++)
        begin
            progWe <= 1'b1;
            progAddr <= i;
            progData <= prog[i];
            @(posedge clk);
        end
        progWe <= 1'b0;
        run <= 1'b1;
        @(negedge clk);
        checkOutputs();
        atEnd = 0;
        while (atEnd < 3)
        begin
            @(posedge clk);
            if (run)
                stepModel();
            // occasional stall cycle
            run <= (randBelow(8) != 0);
            @(negedge clk);
            checkOutputs();
            if (mPc == (progLen - 1) * 4)
                atEnd = atEnd + 1;
        end
        $display("test %0d: %0d words, %0d errors", t, progLen, errorCount - errBefore);
    endtask

    initial
    begin
        seed = 32'hc99734f6;
        arstN = 1'b0;
        run = 1'b0;
        progWe = 1'b0;
        progAddr = '0;
        progData = '0;
        for (int t = 0; t < numTests; t++)
            runTest(t);
        $display("%0d tests, %0d checks, %0d errors", numTests, checkCount, errorCount);
        if (errorCount == 0)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== compile.f ====
rvPkg.sv
ctrlIf.sv
mainDeco.sv
controller.sv
alu.sv
regFile.sv
datapath.sv
instrMem.sv
dataMem.sv
riscvTop.sv
riscvSva.sv
riscvTb.sv

// ==== Bender.yml ====
package:
  name: riscv_subsystem

sources:
  - files:
      - rvPkg.sv
      - ctrlIf.sv
      - mainDeco.sv
      - controller.sv
      - alu.sv
      - regFile.sv
      - datapath.sv
      - instrMem.sv
      - dataMem.sv
      - riscvTop.sv
  - target: test
    files:
      - riscvSva.sv
      - riscvTb.sv
